// File: design/chs_board_pkg.sv
// Shared widths, vector types, request structs, register offsets and FSM states
package chs_board_pkg;

  //////////////////////////////////////////////////////////////////////
  // Widths and constants
  //////////////////////////////////////////////////////////////////////

  localparam int unsigned ADDR_W          = 32;
  localparam int unsigned DATA_W          = 32;
  localparam int unsigned LED_W           = 8;
  localparam int unsigned FAN_W           = 4;
  localparam int unsigned DELAY_W         = 16;

  // soc_clk cycles per RTC half period, full period is twice this
  localparam int unsigned RTC_HALF_PERIOD = 25;
  localparam int unsigned FAN_PRESCALE    = 4;
  localparam int unsigned FAN_SLOTS       = 16;
  localparam int unsigned MEM_FIFO_DEPTH  = 4;

  // Counter widths derived from the constants above
  localparam int unsigned RTC_CNT_W       = $clog2(RTC_HALF_PERIOD);
  localparam int unsigned FAN_PRESC_W     = $clog2(FAN_PRESCALE);
  localparam int unsigned FAN_SLOT_W      = $clog2(FAN_SLOTS);
  localparam int unsigned MEM_PTR_W       = $clog2(MEM_FIFO_DEPTH);
  localparam int unsigned MEM_CNT_W       = MEM_PTR_W + 1;

  //////////////////////////////////////////////////////////////////////
  // Types
  //////////////////////////////////////////////////////////////////////

  typedef logic [ADDR_W-1:0]      addr_t;
  typedef logic [DATA_W-1:0]      data_t;
  typedef logic [LED_W-1:0]       led_t;
  typedef logic [FAN_W-1:0]       fan_t;
  typedef logic [DELAY_W-1:0]     delay_t;
  typedef logic [RTC_CNT_W-1:0]   rtc_cnt_t;
  typedef logic [FAN_PRESC_W-1:0] fan_presc_t;
  typedef logic [FAN_SLOT_W-1:0]  fan_slot_t;
  typedef logic [MEM_PTR_W-1:0]   mem_ptr_t;
  typedef logic [MEM_CNT_W-1:0]   mem_cnt_t;

  typedef struct packed {
    logic  write;
    addr_t addr;
    data_t data;
  } reg_req_t;

  typedef struct packed {
    logic  write;
    addr_t addr;
    data_t data;
  } mem_req_t;

  typedef enum logic {
    IDLE,
    RESP
  } reg_state_t;

  // Register byte offsets
  localparam addr_t REG_LEDS      = 32'h0000_0000;
  localparam addr_t REG_FAN_CTL   = 32'h0000_0004;
  localparam addr_t REG_FAN_OVR   = 32'h0000_0008;
  localparam addr_t REG_MEM_DELAY = 32'h0000_000C;

endpackage

// File: design/rtc_divider.sv
// RTC divider producing a slow square wave from soc_clk
`timescale 1ns/1ns

module rtc_divider (
  input  logic soc_clk,
  input  logic rst_n,
  output logic rtc_o
);

  chs_board_pkg::rtc_cnt_t cnt_q;
  logic                    wrap;

  // Last cycle of a half period
  assign wrap = (cnt_q == chs_board_pkg::rtc_cnt_t'(chs_board_pkg::RTC_HALF_PERIOD - 1));

  always_ff @(posedge soc_clk or negedge rst_n) begin
    if (!rst_n) begin
      cnt_q <= '0;
      rtc_o <= 1'b0;
    end else if (wrap) begin
      cnt_q <= '0;
      rtc_o <= ~rtc_o;
    end else begin
      cnt_q <= cnt_q + chs_board_pkg::rtc_cnt_t'(1);
    end
  end

endmodule

// File: design/fan_pwm.sv
// Fan PWM generator with a prescaler and a 16-slot period
`timescale 1ns/1ns

module fan_pwm (
  input  logic                soc_clk,
  input  logic                rst_n,
  input  chs_board_pkg::fan_t fan_setting_i,
  output logic                fan_pwm_o
);

  chs_board_pkg::fan_presc_t presc_q;
  chs_board_pkg::fan_slot_t  slot_q;
  chs_board_pkg::fan_t       setting_q;
  chs_board_pkg::fan_t       setting_cur;
  logic                      slot_end;
  logic                      period_start;

  assign slot_end     = (presc_q == chs_board_pkg::fan_presc_t'(chs_board_pkg::FAN_PRESCALE - 1));
  assign period_start = (presc_q == '0) && (slot_q == '0);

  // New setting takes effect from the first slot of the period
  assign setting_cur  = period_start ? fan_setting_i : setting_q;

  always_ff @(posedge soc_clk or negedge rst_n) begin
    if (!rst_n) begin
      presc_q   <= '0;
      slot_q    <= '0;
      setting_q <= '0;
      fan_pwm_o <= 1'b0;
    end else begin
      presc_q   <= slot_end ? '0 : presc_q + chs_board_pkg::fan_presc_t'(1);
      if (slot_end) begin
        if (slot_q == chs_board_pkg::fan_slot_t'(chs_board_pkg::FAN_SLOTS - 1)) begin
          slot_q <= '0;
        end else begin
          slot_q <= slot_q + chs_board_pkg::fan_slot_t'(1);
        end
      end
      setting_q <= setting_cur;
      fan_pwm_o <= (chs_board_pkg::fan_t'(slot_q) < setting_cur);
    end
  end

endmodule

// File: design/board_cfg_regs.sv
// Board configuration registers for LEDs, fan control and memory delay
`timescale 1ns/1ns

module board_cfg_regs (
  input  logic                     soc_clk,
  input  logic                     rst_n,
  input  chs_board_pkg::reg_req_t  reg_req_i,
  input  logic                     reg_req_valid_i,
  output logic                     reg_req_ready_o,
  output chs_board_pkg::data_t     reg_rsp_rdata_o,
  output logic                     reg_rsp_valid_o,
  input  logic                     reg_rsp_ready_i,
  input  chs_board_pkg::fan_t      fan_sw_i,
  output chs_board_pkg::led_t      leds_o,
  output chs_board_pkg::fan_t      fan_setting_o,
  output chs_board_pkg::delay_t    mem_delay_o
);

  chs_board_pkg::reg_state_t state_q, state_d;
  chs_board_pkg::led_t       leds_q, leds_d;
  chs_board_pkg::fan_t       fan_ctl_q, fan_ctl_d;
  logic                      fan_ovr_q, fan_ovr_d;
  chs_board_pkg::delay_t     mem_delay_q, mem_delay_d;
  chs_board_pkg::data_t      rdata_d, rdata_q;
  logic                      req_fire;
  logic                      wr_fire;

  // One request in flight at a time
  assign reg_req_ready_o = (state_q == chs_board_pkg::IDLE);
  assign reg_rsp_valid_o = (state_q == chs_board_pkg::RESP);
  assign req_fire        = reg_req_valid_i & reg_req_ready_o;
  assign wr_fire         = req_fire & reg_req_i.write;

  //////////////////////////////////////////////////////////////////////
  // Next register values
  //////////////////////////////////////////////////////////////////////

  always_comb begin
    leds_d      = leds_q;
    fan_ovr_d   = fan_ovr_q;
    mem_delay_d = mem_delay_q;
    // Switches win unless override is set
    fan_ctl_d   = fan_ovr_q ? fan_ctl_q : fan_sw_i;
    if (wr_fire) begin
      case (reg_req_i.addr)
        chs_board_pkg::REG_LEDS:      leds_d = chs_board_pkg::led_t'(reg_req_i.data);
        chs_board_pkg::REG_FAN_CTL: begin
          if (fan_ovr_q) begin
            fan_ctl_d = chs_board_pkg::fan_t'(reg_req_i.data);
          end
        end
        chs_board_pkg::REG_FAN_OVR:   fan_ovr_d = reg_req_i.data[0];
        chs_board_pkg::REG_MEM_DELAY: mem_delay_d = chs_board_pkg::delay_t'(reg_req_i.data);
        default: ;
      endcase
    end
  end

  // Response shows the value the register holds after this access
  always_comb begin
    case (reg_req_i.addr)
      chs_board_pkg::REG_LEDS:      rdata_d = chs_board_pkg::data_t'(leds_d);
      chs_board_pkg::REG_FAN_CTL:   rdata_d = chs_board_pkg::data_t'(fan_ctl_d);
      chs_board_pkg::REG_FAN_OVR:   rdata_d = chs_board_pkg::data_t'(fan_ovr_d);
      chs_board_pkg::REG_MEM_DELAY: rdata_d = chs_board_pkg::data_t'(mem_delay_d);
      default:                      rdata_d = '0;
    endcase
  end

  always_comb begin
    state_d = state_q;
    case (state_q)
      chs_board_pkg::IDLE: if (req_fire) state_d = chs_board_pkg::RESP;
      chs_board_pkg::RESP: if (reg_rsp_ready_i) state_d = chs_board_pkg::IDLE;
      default:             state_d = chs_board_pkg::IDLE;
    endcase
  end

  always_ff @(posedge soc_clk or negedge rst_n) begin
    if (!rst_n) begin
      state_q     <= chs_board_pkg::IDLE;
      leds_q      <= '0;
      fan_ctl_q   <= '0;
      fan_ovr_q   <= 1'b0;
      mem_delay_q <= '0;
    end else begin
      state_q     <= state_d;
      leds_q      <= leds_d;
      fan_ctl_q   <= fan_ctl_d;
      fan_ovr_q   <= fan_ovr_d;
      mem_delay_q <= mem_delay_d;
    end
  end

  always_ff @(posedge soc_clk) begin
    if (req_fire) begin
      rdata_q <= rdata_d;
    end
  end

  assign reg_rsp_rdata_o = rdata_q;
  assign leds_o          = leds_q;
  assign fan_setting_o   = fan_ctl_q;
  assign mem_delay_o     = mem_delay_q;

endmodule

// File: design/mem_delay_fifo.sv
// Memory request buffer releasing each entry after its programmed delay
`timescale 1ns/1ns

module mem_delay_fifo (
  input  logic                    soc_clk,
  input  logic                    rst_n,
  input  chs_board_pkg::delay_t   mem_delay_i,
  input  chs_board_pkg::mem_req_t mem_in_i,
  input  logic                    mem_in_valid_i,
  output logic                    mem_in_ready_o,
  output chs_board_pkg::mem_req_t mem_out_o,
  output logic                    mem_out_valid_o,
  input  logic                    mem_out_ready_i
);

  localparam int unsigned Depth = chs_board_pkg::MEM_FIFO_DEPTH;

  chs_board_pkg::mem_req_t data_q    [Depth];
  chs_board_pkg::delay_t   release_q [Depth];
  logic [Depth-1:0]        ripe_q;
  logic [Depth-1:0]        due;
  chs_board_pkg::delay_t   now_q;
  chs_board_pkg::mem_ptr_t wr_ptr_q, rd_ptr_q;
  chs_board_pkg::mem_cnt_t cnt_q;
  logic                    push, pop;

  // Due once the timestamp has reached the release time, wrap-safe
  // for delays below half the timestamp range
  always_comb begin
    chs_board_pkg::delay_t elapsed;
    for (int i = 0; i < Depth; i++) begin
      elapsed = now_q - release_q[i];
      due[i]  = ripe_q[i] | ~elapsed[chs_board_pkg::DELAY_W-1];
    end
  end

  assign mem_in_ready_o  = (cnt_q != chs_board_pkg::mem_cnt_t'(Depth));
  assign mem_out_valid_o = (cnt_q != '0) && due[rd_ptr_q];
  assign mem_out_o       = data_q[rd_ptr_q];
  assign push            = mem_in_valid_i & mem_in_ready_o;
  assign pop             = mem_out_valid_o & mem_out_ready_i;

  //////////////////////////////////////////////////////////////////////
  // Control state
  //////////////////////////////////////////////////////////////////////

  always_ff @(posedge soc_clk or negedge rst_n) begin
    if (!rst_n) begin
      now_q    <= '0;
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      cnt_q    <= '0;
      ripe_q   <= '0;
    end else begin
      now_q  <= now_q + chs_board_pkg::delay_t'(1);
      // Sticky so a long stall cannot pull back a released head
      ripe_q <= due;
      if (push) begin
        wr_ptr_q         <= wr_ptr_q + chs_board_pkg::mem_ptr_t'(1);
        ripe_q[wr_ptr_q] <= 1'b0;
      end
      if (pop) begin
        rd_ptr_q <= rd_ptr_q + chs_board_pkg::mem_ptr_t'(1);
      end
      if (push && !pop) begin
        cnt_q <= cnt_q + chs_board_pkg::mem_cnt_t'(1);
      end else if (pop && !push) begin
        cnt_q <= cnt_q - chs_board_pkg::mem_cnt_t'(1);
      end
    end
  end

  // Payload and release stamp
  always_ff @(posedge soc_clk) begin
    if (push) begin
      data_q[wr_ptr_q]    <= mem_in_i;
      release_q[wr_ptr_q] <= now_q + mem_delay_i;
    end
  end

endmodule

// File: design/chs_board_top.sv
// Board helper top level with RTC divider, config registers, fan PWM and delay line
`timescale 1ns/1ns

module chs_board_top (
  input  logic                    soc_clk,
  input  logic                    rst_n,
  // Config register access
  input  chs_board_pkg::reg_req_t reg_req_i,
  input  logic                    reg_req_valid_i,
  output logic                    reg_req_ready_o,
  output chs_board_pkg::data_t    reg_rsp_rdata_o,
  output logic                    reg_rsp_valid_o,
  input  logic                    reg_rsp_ready_i,
  // Board IO
  input  chs_board_pkg::fan_t     fan_sw_i,
  output chs_board_pkg::led_t     leds_o,
  output logic                    fan_pwm_o,
  output logic                    rtc_o,
  // Memory request path
  input  chs_board_pkg::mem_req_t mem_in_i,
  input  logic                    mem_in_valid_i,
  output logic                    mem_in_ready_o,
  output chs_board_pkg::mem_req_t mem_out_o,
  output logic                    mem_out_valid_o,
  input  logic                    mem_out_ready_i
);

  chs_board_pkg::fan_t   fan_setting;
  chs_board_pkg::delay_t mem_delay;

  rtc_divider i_rtc_divider (
    .soc_clk ( soc_clk ),
    .rst_n   ( rst_n   ),
    .rtc_o   ( rtc_o   )
  );

  board_cfg_regs i_board_cfg_regs (
    .soc_clk         ( soc_clk         ),
    .rst_n           ( rst_n           ),
    .reg_req_i       ( reg_req_i       ),
    .reg_req_valid_i ( reg_req_valid_i ),
    .reg_req_ready_o ( reg_req_ready_o ),
    .reg_rsp_rdata_o ( reg_rsp_rdata_o ),
    .reg_rsp_valid_o ( reg_rsp_valid_o ),
    .reg_rsp_ready_i ( reg_rsp_ready_i ),
    .fan_sw_i        ( fan_sw_i        ),
    .leds_o          ( leds_o          ),
    .fan_setting_o   ( fan_setting     ),
    .mem_delay_o     ( mem_delay       )
  );

  fan_pwm i_fan_pwm (
    .soc_clk       ( soc_clk     ),
    .rst_n         ( rst_n       ),
    .fan_setting_i ( fan_setting ),
    .fan_pwm_o     ( fan_pwm_o   )
  );

  // SoC side pushes requests, memory side drains them
  mem_delay_fifo i_mem_delay_fifo (
    .soc_clk         ( soc_clk         ),
    .rst_n           ( rst_n           ),
    .mem_delay_i     ( mem_delay       ),
    .mem_in_i        ( mem_in_i        ),
    .mem_in_valid_i  ( mem_in_valid_i  ),
    .mem_in_ready_o  ( mem_in_ready_o  ),
    .mem_out_o       ( mem_out_o       ),
    .mem_out_valid_o ( mem_out_valid_o ),
    .mem_out_ready_i ( mem_out_ready_i )
  );

endmodule

// File: verif/chs_board_tb.sv
// Testbench for chs_board_top covering registers, fan override, fan PWM, RTC and delay line
`timescale 1ns/1ns

module chs_board_tb;

  localparam int REG_N   = 11;
  localparam int FAN_N   = 3;
  localparam int DLY_N   = 3;
  localparam int REQ_N   = 6;
  localparam int BP_N    = chs_board_pkg::MEM_FIFO_DEPTH;
  // Longest wait of one table entry covers the PWM window and register write
  localparam int MAX_LAT = 256;
  localparam int LIMIT   = (REG_N + FAN_N + DLY_N * REQ_N + BP_N) * MAX_LAT + 1000;

  typedef struct packed {
    logic                 wr;
    chs_board_pkg::addr_t addr;
    chs_board_pkg::data_t wdata;
    chs_board_pkg::fan_t  sw;
    chs_board_pkg::data_t exp_rdata;
    chs_board_pkg::led_t  exp_leds;
  } reg_row_t;

  logic                    soc_clk, rst_n;
  chs_board_pkg::reg_req_t reg_req_i;
  logic                    reg_req_valid_i, reg_req_ready_o, reg_rsp_valid_o, reg_rsp_ready_i;
  chs_board_pkg::data_t    reg_rsp_rdata_o;
  chs_board_pkg::fan_t     fan_sw_i;
  chs_board_pkg::led_t     leds_o;
  logic                    fan_pwm_o, rtc_o;
  chs_board_pkg::mem_req_t mem_in_i, mem_out_o;
  logic                    mem_in_valid_i, mem_in_ready_o, mem_out_valid_o, mem_out_ready_i;

  // Rows 0 to 5 cover plain access and rows 6 to 10 the fan override
  reg_row_t reg_tab [REG_N] = '{
    '{1'b1, chs_board_pkg::REG_LEDS, 32'h0000_00A5, 4'h0, 32'h0000_00A5, 8'hA5},
    '{1'b0, chs_board_pkg::REG_LEDS, 32'h0000_0000, 4'h0, 32'h0000_00A5, 8'hA5},
    '{1'b1, chs_board_pkg::REG_LEDS, 32'hFFFF_FF3C, 4'h0, 32'h0000_003C, 8'h3C},
    '{1'b1, chs_board_pkg::REG_MEM_DELAY, 32'h0001_1234, 4'h0, 32'h0000_1234, 8'h3C},
    '{1'b0, chs_board_pkg::REG_MEM_DELAY, 32'h0000_0000, 4'h0, 32'h0000_1234, 8'h3C},
    '{1'b0, 32'h0000_0010, 32'h0000_0000, 4'h0, 32'h0000_0000, 8'h3C},
    '{1'b0, chs_board_pkg::REG_FAN_CTL, 32'h0000_0000, 4'h9, 32'h0000_0009, 8'h3C},
    '{1'b1, chs_board_pkg::REG_FAN_CTL, 32'h0000_0003, 4'h9, 32'h0000_0009, 8'h3C},
    '{1'b1, chs_board_pkg::REG_FAN_OVR, 32'h0000_0003, 4'h9, 32'h0000_0001, 8'h3C},
    '{1'b1, chs_board_pkg::REG_FAN_CTL, 32'h0000_0006, 4'h9, 32'h0000_0006, 8'h3C},
    '{1'b0, chs_board_pkg::REG_FAN_CTL, 32'h0000_0000, 4'hC, 32'h0000_0006, 8'h3C}
  };
  int fan_tab [FAN_N] = '{0, 5, 15};
  int dly_tab [DLY_N] = '{0, 3, 10};

  int                      errors = 0;
  int                      err_mark = 0;
  int                      tests = 0;
  int                      failed = 0;
  int                      cyc = 0;
  integer                  seed;
  chs_board_pkg::mem_req_t exp_q [$];
  int                      acc_q [$];

  chs_board_top i_dut (.*);

  initial begin
    soc_clk = 1'b0;
    forever #20 soc_clk = ~soc_clk;
  end

  initial begin
    while (cyc < LIMIT) begin
      @(posedge soc_clk);
      cyc++;
    end
    $display("Timeout: the run did not finish within %0d cycles", LIMIT);
    $display("Some tests failed");
    $finish;
  end

  task automatic report_mismatch(input string msg);
    errors++;
    $display("MISMATCH at %0t ns: %s", $time, msg);
  endtask

  task automatic finish_test(input string name);
    tests++;
    if (errors == err_mark) begin
      $display("Test %s passed", name);
    end else begin
      failed++;
      $display("Test %s failed with %0d mismatches", name, errors - err_mark);
    end
    err_mark = errors;
  endtask

  //////////////////////////////////////////////////////////////////////
  // Bus helpers called at a falling edge
  //////////////////////////////////////////////////////////////////////

  task automatic reg_access(input logic wr, input chs_board_pkg::addr_t addr,
                            input chs_board_pkg::data_t wdata, input int hold,
                            output chs_board_pkg::data_t rdata);
    @(negedge soc_clk);
    reg_req_i       = '{write: wr, addr: addr, data: wdata};
    reg_req_valid_i = 1'b1;
    while (!reg_req_ready_o) @(negedge soc_clk);
    @(negedge soc_clk);
    reg_req_valid_i = 1'b0;
    if (!reg_rsp_valid_o) report_mismatch("no register response one cycle after acceptance");
    if (reg_req_ready_o) report_mismatch("reg_req_ready_o high while a response is pending");
    rdata = reg_rsp_rdata_o;
    repeat (hold) begin
      @(negedge soc_clk);
      if (!reg_rsp_valid_o || reg_rsp_rdata_o !== rdata) begin
        report_mismatch("register response changed while held");
      end
      if (reg_req_ready_o) report_mismatch("reg_req_ready_o high while a response is pending");
    end
    reg_rsp_ready_i = 1'b1;
    @(negedge soc_clk);
    reg_rsp_ready_i = 1'b0;
  endtask

  task automatic send_requests(input int n);
    logic [95:0]             rnd;
    chs_board_pkg::mem_req_t req;
    for (int k = 0; k < n; k++) begin
      rnd            = {$random(seed), $random(seed), $random(seed)};
      req            = rnd[$bits(chs_board_pkg::mem_req_t)-1:0];
      mem_in_i       = req;
      mem_in_valid_i = 1'b1;
      while (!mem_in_ready_o) @(negedge soc_clk);
      exp_q.push_back(req);
      acc_q.push_back(cyc);
      @(negedge soc_clk);
    end
    mem_in_valid_i = 1'b0;
  endtask

  task automatic drain_requests(input int n, input int min_lat);
    chs_board_pkg::mem_req_t exp;
    int                      acc;
    int                      got;
    got = 0;
    while (got < n) begin
      if (mem_out_valid_o && mem_out_ready_i) begin
        exp = exp_q.pop_front();
        acc = acc_q.pop_front();
        if (mem_out_o !== exp) begin
          report_mismatch($sformatf("mem_out_o is %h, expected %h", mem_out_o, exp));
        end
        if (cyc - acc < min_lat) begin
          report_mismatch($sformatf("latency %0d below %0d", cyc - acc, min_lat));
        end
        got++;
      end
      @(negedge soc_clk);
    end
  endtask

  //////////////////////////////////////////////////////////////////////
  // Test sequence
  //////////////////////////////////////////////////////////////////////

  initial begin
    chs_board_pkg::data_t rd;
    logic                 exp_rtc;
    int                   high;
    seed            = 32'h109cef81;
    rst_n           = 1'b0;
    reg_req_i       = '0;
    reg_req_valid_i = 1'b0;
    reg_rsp_ready_i = 1'b0;
    fan_sw_i        = '0;
    mem_in_i        = '0;
    mem_in_valid_i  = 1'b0;
    mem_out_ready_i = 1'b0;
    repeat (4) @(negedge soc_clk);
    if (reg_rsp_valid_o || mem_out_valid_o || rtc_o || fan_pwm_o) begin
      report_mismatch("an output is high during reset");
    end
    rst_n = 1'b1;

    // RTC output flips after every 25 cycles of run time
    for (int k = 1; k <= 500; k++) begin
      @(negedge soc_clk);
      exp_rtc = ((k / chs_board_pkg::RTC_HALF_PERIOD) % 2) == 1;
      if (rtc_o !== exp_rtc) report_mismatch($sformatf("rtc_o wrong after %0d cycles", k));
    end
    finish_test("rtc_divider");

    for (int i = 0; i < REG_N; i++) begin
      fan_sw_i = reg_tab[i].sw;
      reg_access(reg_tab[i].wr, reg_tab[i].addr, reg_tab[i].wdata, i % 3, rd);
      if (rd !== reg_tab[i].exp_rdata) begin
        report_mismatch($sformatf("row %0d read %h, expected %h", i, rd, reg_tab[i].exp_rdata));
      end
      if (leds_o !== reg_tab[i].exp_leds) report_mismatch($sformatf("row %0d leds_o wrong", i));
      if (i == 5) finish_test("register_access");
    end
    finish_test("fan_override");

    for (int i = 0; i < FAN_N; i++) begin
      reg_access(1'b1, chs_board_pkg::REG_FAN_CTL, chs_board_pkg::data_t'(fan_tab[i]), 0, rd);
      repeat (2 * 64) @(negedge soc_clk);
      high = 0;
      repeat (64) begin
        @(negedge soc_clk);
        if (fan_pwm_o) high++;
      end
      if (high != fan_tab[i] * chs_board_pkg::FAN_PRESCALE) begin
        report_mismatch($sformatf("setting %0d gave %0d high cycles", fan_tab[i], high));
      end
    end
    finish_test("fan_pwm");

    mem_out_ready_i = 1'b1;
    for (int i = 0; i < DLY_N; i++) begin
      reg_access(1'b1, chs_board_pkg::REG_MEM_DELAY, chs_board_pkg::data_t'(dly_tab[i]), 0, rd);
      fork
        send_requests(REQ_N);
        drain_requests(REQ_N, (dly_tab[i] > 1) ? dly_tab[i] : 1);
      join
    end
    finish_test("mem_delay");

    mem_out_ready_i = 1'b0;
    reg_access(1'b1, chs_board_pkg::REG_MEM_DELAY, '0, 0, rd);
    send_requests(BP_N);
    if (mem_in_ready_o) report_mismatch("mem_in_ready_o high with the buffer full");
    repeat (4) begin
      if (!mem_out_valid_o || mem_out_o !== exp_q[0]) report_mismatch("head not held");
      @(negedge soc_clk);
    end
    mem_out_ready_i = 1'b1;
    drain_requests(BP_N, 1);
    finish_test("back_pressure");

    $display("Tests run: %0d, failed: %0d, mismatches: %0d", tests, failed, errors);
    if (errors == 0) begin
      $display("All tests passed");
    end else begin
      $display("Some tests failed");
    end
    $finish;
  end

endmodule

// File: chs_board_top.f
design/chs_board_pkg.sv
design/rtc_divider.sv
design/fan_pwm.sv
design/board_cfg_regs.sv
design/mem_delay_fifo.sv
design/chs_board_top.sv
verif/chs_board_tb.sv

// File: Makefile
# Verilator build and run for the board helper testbench

all: run

obj_dir/Vchs_board_tb: chs_board_top.f $(shell cat chs_board_top.f)
	verilator --binary --top-module chs_board_tb -f chs_board_top.f

run: obj_dir/Vchs_board_tb
	@out=$$(./obj_dir/Vchs_board_tb); echo "$$out"; \
	echo "$$out" | grep -qx "All tests passed"

clean:
	rm -rf obj_dir

.PHONY: all run clean
